//--- rtl/hk_bus_pkg.sv
package hk_bus_pkg;

    // wishbone side widths.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // offset within the register page.
    localparam int OFS_W = 8;

    // gpio block.
    localparam logic [OFS_W-1:0] GPIO_DATA_OFS = 8'h00;
    localparam logic [OFS_W-1:0] GPIO_OE_OFS   = 8'h04;
    localparam logic [OFS_W-1:0] GPIO_IN_OFS   = 8'h08;

    // sysctrl block with one bit per register.
    localparam logic [OFS_W-1:0] PLL_OUT_OFS   = 8'h0C;
    localparam logic [OFS_W-1:0] TRAP_OUT_OFS  = 8'h10;
    localparam logic [OFS_W-1:0] IRQ7_SRC_OFS  = 8'h14;

    // block that answers an in-page access.
    typedef enum logic [1:0] {
        SEL_NONE    = 2'd0,
        SEL_GPIO    = 2'd1,
        SEL_SYSCTRL = 2'd2
    } periph_sel_e;

endpackage

//--- rtl/hk_pin_pkg.sv
package hk_pin_pkg;

    // routing control bits from the sysctrl block.
    typedef struct packed {
        logic pll_dest;   // 1 puts pll clock on gpio.
        logic trap_dest;  // 1 puts trap on top gpio bit.
        logic irq7_src;   // 1 takes irq7 from gpio input.
    } route_cfg_t;

    // fixed gpio positions for the shared pins.
    localparam int PLL_GPIO_BIT  = 0;
    localparam int IRQ7_GPIO_BIT = 1;

endpackage

//--- rtl/hk_iomem_if.sv
interface hk_iomem_if;

    logic [hk_bus_pkg::OFS_W-1:0]  addr;
    logic [hk_bus_pkg::DATA_W-1:0] wdata;
    logic [hk_bus_pkg::STRB_W-1:0] wstrb;
    logic                          valid;
    logic [hk_bus_pkg::DATA_W-1:0] rdata;
    logic                          ready;

    modport controller (
        output addr,
        output wdata,
        output wstrb,
        output valid,
        input  rdata,
        input  ready
    );

    modport peripheral (
        input  addr,
        input  wdata,
        input  wstrb,
        input  valid,
        output rdata,
        output ready
    );

endinterface

//--- rtl/hk_bus_ctrl.sv
module hk_bus_ctrl #(
    parameter logic [31:0] BASE_ADR = 32'h2F00_0000
) (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic [hk_bus_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [hk_bus_pkg::DATA_W-1:0] wb_dat_i,
    input  logic [hk_bus_pkg::STRB_W-1:0] wb_sel_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    output logic [hk_bus_pkg::DATA_W-1:0] wb_dat_o,
    output logic                          wb_ack_o,

    hk_iomem_if.controller                gpio_bus,
    hk_iomem_if.controller                sys_bus
);

    logic                          req;
    logic                          page_hit;
    logic [hk_bus_pkg::OFS_W-1:0]  ofs;
    logic [hk_bus_pkg::STRB_W-1:0] wstrb;
    hk_bus_pkg::periph_sel_e       sel;
    logic                          none_ack;

    assign req      = wb_cyc_i && wb_stb_i;
    assign ofs      = wb_adr_i[hk_bus_pkg::OFS_W-1:0];
    assign page_hit = (wb_adr_i[hk_bus_pkg::ADDR_W-1:hk_bus_pkg::OFS_W] ==
                       BASE_ADR[hk_bus_pkg::ADDR_W-1:hk_bus_pkg::OFS_W]);
    assign wstrb    = wb_sel_i & {hk_bus_pkg::STRB_W{wb_we_i}};

    // decode the offset into a block window.
    always_comb begin
        if (!page_hit) begin
            sel = hk_bus_pkg::SEL_NONE;
        end else if (ofs < hk_bus_pkg::PLL_OUT_OFS) begin
            sel = hk_bus_pkg::SEL_GPIO;
        end else if (ofs <= hk_bus_pkg::IRQ7_SRC_OFS) begin
            sel = hk_bus_pkg::SEL_SYSCTRL;
        end else begin
            sel = hk_bus_pkg::SEL_NONE;
        end
    end

    // valid and strobes go only to the selected block.
    assign gpio_bus.addr  = ofs;
    assign gpio_bus.wdata = wb_dat_i;
    assign gpio_bus.valid = req && (sel == hk_bus_pkg::SEL_GPIO);
    assign gpio_bus.wstrb = (sel == hk_bus_pkg::SEL_GPIO) ? wstrb : '0;

    assign sys_bus.addr   = ofs;
    assign sys_bus.wdata  = wb_dat_i;
    assign sys_bus.valid  = req && (sel == hk_bus_pkg::SEL_SYSCTRL);
    assign sys_bus.wstrb  = (sel == hk_bus_pkg::SEL_SYSCTRL) ? wstrb : '0;

    // in-page hole answered here with zero data.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= req && page_hit && (sel == hk_bus_pkg::SEL_NONE) && !none_ack;
        end
    end

    // none_ack never rises for an out-of-page access.
    always_comb begin
        case (sel)
            hk_bus_pkg::SEL_GPIO: begin
                wb_ack_o = gpio_bus.ready;
                wb_dat_o = gpio_bus.ready ? gpio_bus.rdata : '0;
            end
            hk_bus_pkg::SEL_SYSCTRL: begin
                wb_ack_o = sys_bus.ready;
                wb_dat_o = sys_bus.ready ? sys_bus.rdata : '0;
            end
            default: begin
                wb_ack_o = none_ack;
                wb_dat_o = '0;
            end
        endcase
    end

endmodule

//--- rtl/hk_sysctrl_regs.sv
module hk_sysctrl_regs (
    input  logic                   clk,
    input  logic                   resetn,

    hk_iomem_if.peripheral         bus,

    output hk_pin_pkg::route_cfg_t route_cfg_o
);

    hk_pin_pkg::route_cfg_t cfg_q;
    logic                   access;

    // ready never rises twice in a row.
    assign access = bus.valid && !bus.ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cfg_q     <= '0;
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= access;
            if (access && bus.wstrb[0]) begin
                case (bus.addr)
                    hk_bus_pkg::PLL_OUT_OFS:  cfg_q.pll_dest  <= bus.wdata[0];
                    hk_bus_pkg::TRAP_OUT_OFS: cfg_q.trap_dest <= bus.wdata[0];
                    hk_bus_pkg::IRQ7_SRC_OFS: cfg_q.irq7_src  <= bus.wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // read data keeps the old value on a write cycle.
    always_ff @(posedge clk) begin
        if (access) begin
            case (bus.addr)
                hk_bus_pkg::PLL_OUT_OFS:  bus.rdata <= {31'd0, cfg_q.pll_dest};
                hk_bus_pkg::TRAP_OUT_OFS: bus.rdata <= {31'd0, cfg_q.trap_dest};
                hk_bus_pkg::IRQ7_SRC_OFS: bus.rdata <= {31'd0, cfg_q.irq7_src};
                default:                  bus.rdata <= '0;
            endcase
        end
    end

    assign route_cfg_o = cfg_q;

endmodule

//--- rtl/hk_gpio_regs.sv
module hk_gpio_regs #(
    parameter int GPIO_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,

    hk_iomem_if.peripheral        bus,

    output logic [GPIO_WIDTH-1:0] gpio_out_o,
    output logic [GPIO_WIDTH-1:0] gpio_oe_o,
    output logic [GPIO_WIDTH-1:0] gpio_in_sync_o
);

    logic [GPIO_WIDTH-1:0] out_q;
    logic [GPIO_WIDTH-1:0] oe_q;
    logic [GPIO_WIDTH-1:0] in_meta;
    logic [GPIO_WIDTH-1:0] in_sync;
    logic                  access;

    assign access = bus.valid && !bus.ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_q     <= '0;
            oe_q      <= '0;
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= access;
            if (access) begin
                // each bit follows the strobe of its byte lane.
                for (int i = 0; i < GPIO_WIDTH; i++) begin
                    if (bus.wstrb[i / 8]) begin
                        if (bus.addr == hk_bus_pkg::GPIO_DATA_OFS) begin
                            out_q[i] <= bus.wdata[i];
                        end
                        if (bus.addr == hk_bus_pkg::GPIO_OE_OFS) begin
                            oe_q[i] <= bus.wdata[i];
                        end
                    end
                end
            end
        end
    end

    // two-flop input synchronizer.
    always_ff @(posedge clk) begin
        in_meta <= gpio_in_i;
        in_sync <= in_meta;
    end

    // zero-extended readback.
    always_ff @(posedge clk) begin
        if (access) begin
            bus.rdata <= '0;
            case (bus.addr)
                hk_bus_pkg::GPIO_DATA_OFS: bus.rdata[GPIO_WIDTH-1:0] <= out_q;
                hk_bus_pkg::GPIO_OE_OFS:   bus.rdata[GPIO_WIDTH-1:0] <= oe_q;
                hk_bus_pkg::GPIO_IN_OFS:   bus.rdata[GPIO_WIDTH-1:0] <= in_sync;
                default: ;
            endcase
        end
    end

    assign gpio_out_o     = out_q;
    assign gpio_oe_o      = oe_q;
    assign gpio_in_sync_o = in_sync;

endmodule

//--- rtl/hk_pin_route.sv
module hk_pin_route #(
    parameter int GPIO_WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  hk_pin_pkg::route_cfg_t route_cfg_i,
    input  logic                   pll_clk_i,
    input  logic                   trap_i,
    input  logic                   irq_ext_i,
    input  logic [GPIO_WIDTH-1:0]  gpio_out_i,
    input  logic [GPIO_WIDTH-1:0]  gpio_oe_i,
    input  logic [GPIO_WIDTH-1:0]  gpio_in_sync_i,

    output logic [GPIO_WIDTH-1:0]  pad_out_o,
    output logic [GPIO_WIDTH-1:0]  pad_oe_o,
    output logic                   pll_clk_o,
    output logic                   trap_o,
    output logic                   irq7_o
);

    localparam int TRAP_GPIO_BIT = GPIO_WIDTH - 1;

    logic irq7_sel;
    logic irq7_meta;
    logic irq7_sync;

    // routed signals override gpio data and force the enable.
    always_comb begin
        pad_out_o = gpio_out_i;
        pad_oe_o  = gpio_oe_i;
        pll_clk_o = pll_clk_i;
        trap_o    = trap_i;
        if (route_cfg_i.pll_dest) begin
            pad_out_o[hk_pin_pkg::PLL_GPIO_BIT] = pll_clk_i;
            pad_oe_o[hk_pin_pkg::PLL_GPIO_BIT]  = 1'b1;
            pll_clk_o                           = 1'b0;
        end
        if (route_cfg_i.trap_dest) begin
            pad_out_o[TRAP_GPIO_BIT] = trap_i;
            pad_oe_o[TRAP_GPIO_BIT]  = 1'b1;
            trap_o                   = 1'b0;
        end
    end

    assign irq7_sel = route_cfg_i.irq7_src ? gpio_in_sync_i[hk_pin_pkg::IRQ7_GPIO_BIT]
                                           : irq_ext_i;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            irq7_meta <= 1'b0;
            irq7_sync <= 1'b0;
        end else begin
            irq7_meta <= irq7_sel;
            irq7_sync <= irq7_meta;
        end
    end

    assign irq7_o = irq7_sync;

endmodule

//--- rtl/housekeeping_top.sv
module housekeeping_top #(
    parameter logic [31:0] BASE_ADR   = 32'h2F00_0000,
    parameter int          GPIO_WIDTH = 8  // 3 or more.
) (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic [hk_bus_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [hk_bus_pkg::DATA_W-1:0] wb_dat_i,
    input  logic [hk_bus_pkg::STRB_W-1:0] wb_sel_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    output logic [hk_bus_pkg::DATA_W-1:0] wb_dat_o,
    output logic                          wb_ack_o,

    input  logic [GPIO_WIDTH-1:0]         gpio_in_i,
    input  logic                          pll_clk_i,
    input  logic                          trap_i,
    input  logic                          irq_ext_i,
    output logic [GPIO_WIDTH-1:0]         pad_out_o,
    output logic [GPIO_WIDTH-1:0]         pad_oe_o,
    output logic                          pll_clk_o,
    output logic                          trap_o,
    output logic                          irq7_o
);

    hk_pin_pkg::route_cfg_t route_cfg;
    logic [GPIO_WIDTH-1:0]  gpio_out;
    logic [GPIO_WIDTH-1:0]  gpio_oe;
    logic [GPIO_WIDTH-1:0]  gpio_in_sync;

    hk_iomem_if gpio_bus ();
    hk_iomem_if sys_bus ();

    hk_bus_ctrl #(
        .BASE_ADR (BASE_ADR)
    ) i_bus_ctrl (
        .clk      (clk),
        .resetn   (resetn),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .gpio_bus (gpio_bus.controller),
        .sys_bus  (sys_bus.controller)
    );

    hk_sysctrl_regs i_sysctrl_regs (
        .clk         (clk),
        .resetn      (resetn),
        .bus         (sys_bus.peripheral),
        .route_cfg_o (route_cfg)
    );

    hk_gpio_regs #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) i_gpio_regs (
        .clk            (clk),
        .resetn         (resetn),
        .gpio_in_i      (gpio_in_i),
        .bus            (gpio_bus.peripheral),
        .gpio_out_o     (gpio_out),
        .gpio_oe_o      (gpio_oe),
        .gpio_in_sync_o (gpio_in_sync)
    );

    hk_pin_route #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) i_pin_route (
        .clk            (clk),
        .resetn         (resetn),
        .route_cfg_i    (route_cfg),
        .pll_clk_i      (pll_clk_i),
        .trap_i         (trap_i),
        .irq_ext_i      (irq_ext_i),
        .gpio_out_i     (gpio_out),
        .gpio_oe_i      (gpio_oe),
        .gpio_in_sync_i (gpio_in_sync),
        .pad_out_o      (pad_out_o),
        .pad_oe_o       (pad_oe_o),
        .pll_clk_o      (pll_clk_o),
        .trap_o         (trap_o),
        .irq7_o         (irq7_o)
    );

endmodule

//--- tb/hk_checker.sv
module hk_checker #(
    parameter logic [31:0] BASE_ADR   = 32'h2F00_0000,
    parameter int          GPIO_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [31:0]           wb_adr_i,
    input  logic [31:0]           wb_dat_i,
    input  logic [3:0]            wb_sel_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [31:0]           wb_rdat_i,
    input  logic                  wb_ack_i,
    input  logic [31:0]           exp_rdat_i,
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,
    input  logic                  pll_clk_i,
    input  logic                  trap_i,
    input  logic                  irq_ext_i,
    input  logic [GPIO_WIDTH-1:0] pad_out_i,
    input  logic [GPIO_WIDTH-1:0] pad_oe_i,
    input  logic                  pll_pin_i,
    input  logic                  trap_pin_i,
    input  logic                  irq7_i,
    output int                    err_cnt_o
);

    hk_pin_pkg::route_cfg_t cfg_sh;
    logic [GPIO_WIDTH-1:0]  out_sh;
    logic [GPIO_WIDTH-1:0]  oe_sh;
    logic [GPIO_WIDTH-1:0]  gin_d1;
    logic [GPIO_WIDTH-1:0]  gin_d2;  // models the input synchronizer.
    logic                   sel_d1;
    logic                   sel_d2;
    logic                   irq_src;
    logic                   in_page;
    logic                   exp_ack;
    int                     stb_age;

    initial err_cnt_o = 0;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        err_cnt_o++;
        $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    // shadow update for an acked write.
    task automatic track_write();
        int i;
        case (wb_adr_i[7:0])
            hk_bus_pkg::GPIO_DATA_OFS, hk_bus_pkg::GPIO_OE_OFS: begin
                for (i = 0; i < GPIO_WIDTH; i++) begin
                    if (wb_sel_i[i / 8] && wb_adr_i[7:0] == hk_bus_pkg::GPIO_DATA_OFS) begin
                        out_sh[i] = wb_dat_i[i];
                    end else if (wb_sel_i[i / 8]) begin
                        oe_sh[i] = wb_dat_i[i];
                    end
                end
            end
            hk_bus_pkg::PLL_OUT_OFS:  if (wb_sel_i[0]) cfg_sh.pll_dest = wb_dat_i[0];
            hk_bus_pkg::TRAP_OUT_OFS: if (wb_sel_i[0]) cfg_sh.trap_dest = wb_dat_i[0];
            hk_bus_pkg::IRQ7_SRC_OFS: if (wb_sel_i[0]) cfg_sh.irq7_src = wb_dat_i[0];
            default: ;
        endcase
    endtask

    task automatic check_pins();
        logic [GPIO_WIDTH-1:0] exp_out;
        logic [GPIO_WIDTH-1:0] exp_oe;
        logic                  exp_pll;
        logic                  exp_trap;
        exp_out  = out_sh;
        exp_oe   = oe_sh;
        exp_pll  = pll_clk_i;
        exp_trap = trap_i;
        if (cfg_sh.pll_dest) begin
            exp_out[hk_pin_pkg::PLL_GPIO_BIT] = pll_clk_i;
            exp_oe[hk_pin_pkg::PLL_GPIO_BIT]  = 1'b1;
            exp_pll                           = 1'b0;
        end
        if (cfg_sh.trap_dest) begin
            exp_out[GPIO_WIDTH-1] = trap_i;  // top bit.
            exp_oe[GPIO_WIDTH-1]  = 1'b1;
            exp_trap              = 1'b0;
        end
        if (pad_out_i !== exp_out) report_mismatch("pad_out_o", exp_out, pad_out_i);
        if (pad_oe_i !== exp_oe) report_mismatch("pad_oe_o", exp_oe, pad_oe_i);
        if (pll_pin_i !== exp_pll) report_mismatch("pll_clk_o", exp_pll, pll_pin_i);
        if (trap_pin_i !== exp_trap) report_mismatch("trap_o", exp_trap, trap_pin_i);
    endtask

    // sampled mid-cycle since inputs only move on the rising edge.
    always @(negedge clk) begin
        if (!resetn) begin
            cfg_sh  = '0;
            out_sh  = '0;
            oe_sh   = '0;
            sel_d1  = 1'b0;
            sel_d2  = 1'b0;
            stb_age = 0;
        end else begin
            in_page = (wb_adr_i[31:8] == BASE_ADR[31:8]);
            exp_ack = wb_cyc_i && wb_stb_i && in_page && (stb_age == 1);
            if (wb_ack_i !== exp_ack) report_mismatch("wb_ack_o", exp_ack, wb_ack_i);
            if (wb_ack_i && wb_we_i && in_page) begin
                track_write();
            end
            if (wb_ack_i && !wb_we_i && wb_rdat_i !== exp_rdat_i) begin
                report_mismatch("wb_dat_o", exp_rdat_i, wb_rdat_i);
            end
            stb_age = (wb_cyc_i && wb_stb_i) ? stb_age + 1 : 0;
            check_pins();
            irq_src = cfg_sh.irq7_src ? gin_d2[hk_pin_pkg::IRQ7_GPIO_BIT] : irq_ext_i;
            if (irq7_i !== sel_d2) report_mismatch("irq7_o", sel_d2, irq7_i);
            sel_d2 = sel_d1;  // two-cycle lag.
            sel_d1 = irq_src;
        end
        gin_d2 = gin_d1;
        gin_d1 = gpio_in_i;
    end

endmodule

//--- tb/tb_housekeeping.sv
module tb_housekeeping;

    localparam logic [31:0] BASE   = 32'h2F00_0000;
    localparam int          GW     = 8;
    localparam logic [31:0] A_DATA = BASE + hk_bus_pkg::GPIO_DATA_OFS;
    localparam logic [31:0] A_OE   = BASE + hk_bus_pkg::GPIO_OE_OFS;
    localparam logic [31:0] A_IN   = BASE + hk_bus_pkg::GPIO_IN_OFS;
    localparam logic [31:0] A_PLL  = BASE + hk_bus_pkg::PLL_OUT_OFS;
    localparam logic [31:0] A_TRAP = BASE + hk_bus_pkg::TRAP_OUT_OFS;
    localparam logic [31:0] A_IRQ7 = BASE + hk_bus_pkg::IRQ7_SRC_OFS;

    typedef struct packed {
        logic          we;
        logic [31:0]   adr;
        logic [31:0]   wdat;
        logic [3:0]    sel;
        logic [31:0]   rdat;  // checked on reads only.
        logic          ack;
        logic [GW-1:0] gin;
        logic          irq;
    } op_t;

    logic          clk;
    logic          resetn;
    logic [31:0]   wb_adr;
    logic [31:0]   wb_dat_w;
    logic [3:0]    wb_sel;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    logic [31:0]   wb_dat_r;
    logic          wb_ack;
    logic [31:0]   exp_rdat;
    logic [GW-1:0] gpio_in;
    logic          pll_clk;
    logic          trap;
    logic          irq_ext;
    logic [GW-1:0] pad_out;
    logic [GW-1:0] pad_oe;
    logic          pll_pin;
    logic          trap_pin;
    logic          irq7;
    int            chk_errors;
    int            cycle_cnt;
    integer        seed;
    logic [31:0]   rnd;
    op_t           ops[$];

    housekeeping_top #(
        .BASE_ADR   (BASE),
        .GPIO_WIDTH (GW)
    ) i_housekeeping_top (
        .clk (clk), .resetn (resetn),
        .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_w), .wb_sel_i (wb_sel),
        .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
        .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
        .gpio_in_i (gpio_in), .pll_clk_i (pll_clk), .trap_i (trap), .irq_ext_i (irq_ext),
        .pad_out_o (pad_out), .pad_oe_o (pad_oe), .pll_clk_o (pll_pin),
        .trap_o (trap_pin), .irq7_o (irq7)
    );

    hk_checker #(
        .BASE_ADR   (BASE),
        .GPIO_WIDTH (GW)
    ) i_checker (
        .clk (clk), .resetn (resetn),
        .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_w), .wb_sel_i (wb_sel),
        .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
        .wb_rdat_i (wb_dat_r), .wb_ack_i (wb_ack), .exp_rdat_i (exp_rdat),
        .gpio_in_i (gpio_in), .pll_clk_i (pll_clk), .trap_i (trap), .irq_ext_i (irq_ext),
        .pad_out_i (pad_out), .pad_oe_i (pad_oe), .pll_pin_i (pll_pin),
        .trap_pin_i (trap_pin), .irq7_i (irq7), .err_cnt_o (chk_errors)
    );

    always #2 clk = ~clk;

    // pll and trap wander freely.
    always @(posedge clk) begin
        rnd = $random(seed);
        pll_clk <= rnd[0];
        trap    <= rnd[1];
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= ops.size() * 6 + 50) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    task automatic add_op(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                          input logic [3:0] sel, input logic [31:0] rdat, input logic ack,
                          input logic [GW-1:0] gin, input logic irq);
        ops.push_back({we, adr, wdat, sel, rdat, ack, gin, irq});
    endtask

    task automatic fill_table();
        // we, address, wdata, sel, rdata, ack, gpio_in, irq_ext.
        add_op(0, A_PLL,  32'h0,         4'hF, 32'h0,  1, 8'h00, 0);
        add_op(0, A_TRAP, 32'h0,         4'hF, 32'h0,  1, 8'h00, 0);
        add_op(0, A_IRQ7, 32'h0,         4'hF, 32'h0,  1, 8'h00, 1);
        add_op(0, A_DATA, 32'h0,         4'hF, 32'h0,  1, 8'h00, 1);
        add_op(0, A_OE,   32'h0,         4'hF, 32'h0,  1, 8'h00, 0);
        add_op(1, A_PLL,  32'hFFFF_FFFF, 4'h1, 32'h0,  1, 8'h00, 1);
        add_op(0, A_PLL,  32'h0,         4'hF, 32'h1,  1, 8'h00, 0);
        add_op(1, A_PLL,  32'h0,         4'hE, 32'h0,  1, 8'h00, 0);  // lane 0 off.
        add_op(0, A_PLL,  32'h0,         4'hF, 32'h1,  1, 8'h00, 1);
        add_op(1, A_TRAP, 32'h1,         4'h1, 32'h0,  1, 8'h00, 1);
        add_op(0, A_TRAP, 32'h0,         4'hF, 32'h1,  1, 8'h00, 0);
        add_op(1, A_TRAP, 32'h0,         4'hE, 32'h0,  1, 8'h00, 0);
        add_op(0, A_TRAP, 32'h0,         4'hF, 32'h1,  1, 8'h00, 0);
        add_op(1, A_DATA, 32'h1234_56A5, 4'hF, 32'h0,  1, 8'h00, 0);
        add_op(0, A_DATA, 32'h0,         4'hF, 32'hA5, 1, 8'h00, 0);
        add_op(1, A_DATA, 32'hFF,        4'hE, 32'h0,  1, 8'h00, 0);
        add_op(0, A_DATA, 32'h0,         4'hF, 32'hA5, 1, 8'h00, 0);
        add_op(1, A_OE,   32'h3C,        4'h1, 32'h0,  1, 8'h00, 0);
        add_op(0, A_OE,   32'h0,         4'hF, 32'h3C, 1, 8'h00, 0);
        add_op(1, A_DATA, 32'h5A,        4'h1, 32'h0,  1, 8'h00, 0);
        add_op(0, A_DATA, 32'h0,         4'hF, 32'h5A, 1, 8'h5A, 0);
        add_op(0, A_IN,   32'h0,         4'hF, 32'h5A, 1, 8'h5A, 0);
        add_op(0, A_IN,   32'h0,         4'hF, 32'h5A, 1, 8'hC3, 0);  // still the old input.
        add_op(0, A_IN,   32'h0,         4'hF, 32'hC3, 1, 8'hC3, 0);
        add_op(1, A_PLL,  32'h0,         4'h1, 32'h0,  1, 8'h00, 0);
        add_op(1, A_TRAP, 32'hFFFF_FFFE, 4'hF, 32'h0,  1, 8'h00, 0);
        add_op(0, A_PLL,  32'h0,         4'hF, 32'h0,  1, 8'h00, 1);
        add_op(0, A_TRAP, 32'h0,         4'hF, 32'h0,  1, 8'h00, 1);
        add_op(1, A_IRQ7, 32'h1,         4'h1, 32'h0,  1, 8'h02, 0);
        add_op(0, A_IRQ7, 32'h0,         4'hF, 32'h1,  1, 8'h00, 1);
        add_op(0, A_IN,   32'h0,         4'hF, 32'h00, 1, 8'h02, 1);
        add_op(0, A_IN,   32'h0,         4'hF, 32'h02, 1, 8'h02, 0);
        add_op(1, A_IRQ7, 32'h0,         4'h2, 32'h0,  1, 8'h00, 0);
        add_op(0, A_IRQ7, 32'h0,         4'hF, 32'h1,  1, 8'h00, 1);
        add_op(1, BASE + 32'h18, 32'hFFFF_FFFF, 4'hF, 32'h0, 1, 8'h00, 0);
        add_op(0, BASE + 32'h18, 32'h0,  4'hF, 32'h0,  1, 8'h00, 0);
        add_op(0, BASE + 32'hFC, 32'h0,  4'hF, 32'h0,  1, 8'h00, 0);
        add_op(1, 32'h2F00_010C, 32'h1,  4'hF, 32'h0,  0, 8'h00, 0);
        add_op(0, 32'h3000_0000, 32'h0,  4'hF, 32'h0,  0, 8'h00, 0);
        add_op(0, A_PLL,  32'h0,         4'hF, 32'h0,  1, 8'h00, 0);
        add_op(0, A_DATA, 32'h0,         4'hF, 32'h5A, 1, 8'h00, 0);
        add_op(0, A_IRQ7, 32'h0,         4'hF, 32'h1,  1, 8'h00, 0);
    endtask

    // one wishbone access followed by one idle cycle.
    task automatic run_op(input op_t op);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= op.we;
        wb_adr   <= op.adr;
        wb_dat_w <= op.wdat;
        wb_sel   <= op.sel;
        exp_rdat <= op.rdat;
        gpio_in  <= op.gin;
        irq_ext  <= op.irq;
        do begin
            @(negedge clk);
            waited++;
        end while (op.ack ? !wb_ack : waited < 3);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_sel     = '0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        exp_rdat   = '0;
        gpio_in    = '0;
        pll_clk    = 1'b0;
        trap       = 1'b0;
        irq_ext    = 1'b0;
        cycle_cnt  = 0;
        seed       = 32'h15eb9afa;
        fill_table();
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        foreach (ops[i]) begin
            run_op(ops[i]);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d in checks", chk_errors);
        if (chk_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/hk_bus_pkg.sv
rtl/hk_pin_pkg.sv
rtl/hk_iomem_if.sv
rtl/hk_bus_ctrl.sv
rtl/hk_sysctrl_regs.sv
rtl/hk_gpio_regs.sv
rtl/hk_pin_route.sv
rtl/housekeeping_top.sv
tb/hk_checker.sv
tb/tb_housekeeping.sv
